//--- logic/mipsPkg.sv
`default_nettype none

package mipsPkg;

	// Internal operations handed from decode to the second stage
	typedef enum logic [4:0] {
		aluAddu,
		aluSubu,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSltu,
		aluSll, // Fixed and variable forms
		aluSrl,
		aluSra,
		aluLui, // Operand already shifted up
		aluMult,
		aluMultu,
		aluDiv,
		aluDivu,
		aluMfhi,
		aluMflo,
		aluMthi,
		aluMtlo,
		memWord, // LW, SW
		memByte, // LB, LBU, SB
		opNone
	} aluOpT;

	localparam logic [5:0] opSpecial = 6'b000000;
	localparam logic [5:0] opAddiu = 6'b001001;
	localparam logic [5:0] opSlti = 6'b001010;
	localparam logic [5:0] opSltiu = 6'b001011;
	localparam logic [5:0] opAndi = 6'b001100;
	localparam logic [5:0] opOri = 6'b001101;
	localparam logic [5:0] opXori = 6'b001110;
	localparam logic [5:0] opLui = 6'b001111;
	localparam logic [5:0] opLw = 6'b100011;
	localparam logic [5:0] opSw = 6'b101011;
	localparam logic [5:0] opLb = 6'b100000;
	localparam logic [5:0] opLbu = 6'b100100;
	localparam logic [5:0] opSb = 6'b101000;

	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd = 6'b100100;
	localparam logic [5:0] fnOr = 6'b100101;
	localparam logic [5:0] fnXor = 6'b100110;
	localparam logic [5:0] fnSlt = 6'b101010;
	localparam logic [5:0] fnSltu = 6'b101011;
	localparam logic [5:0] fnSll = 6'b000000;
	localparam logic [5:0] fnSrl = 6'b000010;
	localparam logic [5:0] fnSra = 6'b000011;
	localparam logic [5:0] fnSllv = 6'b000100;
	localparam logic [5:0] fnSrlv = 6'b000110;
	localparam logic [5:0] fnSrav = 6'b000111;
	localparam logic [5:0] fnMult = 6'b011000;
	localparam logic [5:0] fnMultu = 6'b011001;
	localparam logic [5:0] fnDiv = 6'b011010;
	localparam logic [5:0] fnDivu = 6'b011011;
	localparam logic [5:0] fnMfhi = 6'b010000;
	localparam logic [5:0] fnMthi = 6'b010001;
	localparam logic [5:0] fnMflo = 6'b010010;
	localparam logic [5:0] fnMtlo = 6'b010011;

	localparam logic [3:0] beWord = 4'b1111;
	localparam logic [3:0] beNone = 4'b0000;

endpackage

`default_nettype wire

//--- logic/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input  logic clk,
	input  logic rst,
	input  logic inValid,
	input  logic [31:0] instruction,
	input  logic [31:0] readData1,
	input  logic [31:0] readData2,
	output logic decValid,
	output mipsPkg::aluOpT decOp,
	output logic [31:0] opA,
	output logic [31:0] opB,
	output logic [4:0] shiftAmount
);

	logic [5:0] opcode;
	logic [5:0] func;
	logic [15:0] immediate;
	logic [4:0] shamt;
	logic [31:0] immSe;
	logic [31:0] immZe;
	logic [31:0] immUp;

	mipsPkg::aluOpT nextOp;
	logic [31:0] nextB;
	logic [4:0] nextShift;

	assign opcode = instruction[31:26];
	assign func = instruction[5:0];
	assign immediate = instruction[15:0];
	assign shamt = instruction[10:6];

	assign immSe = {{16{immediate[15]}}, immediate};
	assign immZe = {16'b0, immediate};
	assign immUp = {immediate, 16'b0};

	// Variable shifts have func[2] set
	assign nextShift = func[2] ? readData1[4:0] : shamt;

	always_comb begin
		nextOp = mipsPkg::opNone;
		nextB = readData2;
		case (opcode)
			mipsPkg::opSpecial: begin
				case (func)
					mipsPkg::fnAddu: nextOp = mipsPkg::aluAddu;
					mipsPkg::fnSubu: nextOp = mipsPkg::aluSubu;
					mipsPkg::fnAnd: nextOp = mipsPkg::aluAnd;
					mipsPkg::fnOr: nextOp = mipsPkg::aluOr;
					mipsPkg::fnXor: nextOp = mipsPkg::aluXor;
					mipsPkg::fnSlt: nextOp = mipsPkg::aluSlt;
					mipsPkg::fnSltu: nextOp = mipsPkg::aluSltu;
					mipsPkg::fnSll, mipsPkg::fnSllv: nextOp = mipsPkg::aluSll;
					mipsPkg::fnSrl, mipsPkg::fnSrlv: nextOp = mipsPkg::aluSrl;
					mipsPkg::fnSra, mipsPkg::fnSrav: nextOp = mipsPkg::aluSra;
					mipsPkg::fnMult: nextOp = mipsPkg::aluMult;
					mipsPkg::fnMultu: nextOp = mipsPkg::aluMultu;
					mipsPkg::fnDiv: nextOp = mipsPkg::aluDiv;
					mipsPkg::fnDivu: nextOp = mipsPkg::aluDivu;
					mipsPkg::fnMfhi: nextOp = mipsPkg::aluMfhi;
					mipsPkg::fnMflo: nextOp = mipsPkg::aluMflo;
					mipsPkg::fnMthi: nextOp = mipsPkg::aluMthi;
					mipsPkg::fnMtlo: nextOp = mipsPkg::aluMtlo;
					default: nextOp = mipsPkg::opNone;
				endcase
			end
			mipsPkg::opAddiu: begin
				nextOp = mipsPkg::aluAddu;
				nextB = immSe;
			end
			mipsPkg::opSlti: begin
				nextOp = mipsPkg::aluSlt;
				nextB = immSe;
			end
			mipsPkg::opSltiu: begin
				nextOp = mipsPkg::aluSltu;
				nextB = immZe;
			end
			mipsPkg::opAndi: begin
				nextOp = mipsPkg::aluAnd;
				nextB = immZe;
			end
			mipsPkg::opOri: begin
				nextOp = mipsPkg::aluOr;
				nextB = immZe;
			end
			mipsPkg::opXori: begin
				nextOp = mipsPkg::aluXor;
				nextB = immZe;
			end
			mipsPkg::opLui: begin
				nextOp = mipsPkg::aluLui;
				nextB = immUp;
			end
			mipsPkg::opLw, mipsPkg::opSw: begin
				nextOp = mipsPkg::memWord;
				nextB = immSe; // Offset from base
			end
			mipsPkg::opLb, mipsPkg::opLbu, mipsPkg::opSb: begin
				nextOp = mipsPkg::memByte;
				nextB = immSe;
			end
			default: nextOp = mipsPkg::opNone;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			decValid <= 1'b0;
		end else begin
			decValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		decOp <= nextOp;
		opA <= readData1;
		opB <= nextB;
		shiftAmount <= nextShift;
	end

	assert property (@(posedge clk) disable iff (rst) inValid |-> !$isunknown(instruction))
		else $error("decodeStage: instruction has unknown bits while valid");

endmodule

`default_nettype wire

//--- logic/aluStage.sv
`timescale 1ns/1ps
`default_nettype none

module aluStage (
	input  logic clk,
	input  logic rst,
	input  logic decValid,
	input  mipsPkg::aluOpT decOp,
	input  logic [31:0] opA,
	input  logic [31:0] opB,
	input  logic [4:0] shiftAmount,
	input  logic [31:0] hi,
	input  logic [31:0] lo,
	output logic outValid,
	output logic [31:0] aluResult,
	output logic [3:0] byteEnable
);

	logic [31:0] address;
	logic [31:0] result;
	logic [3:0] enable;
	logic signedLess;
	logic unsignedLess;

	assign address = opA + opB; // Shared by ADDU, ADDIU and memory ops
	assign signedLess = $signed(opA) < $signed(opB);
	assign unsignedLess = opA < opB;

	always_comb begin
		result = '0;
		enable = mipsPkg::beNone;
		case (decOp)
			mipsPkg::aluAddu: result = address;
			mipsPkg::aluSubu: result = opA - opB;
			mipsPkg::aluAnd: result = opA & opB;
			mipsPkg::aluOr: result = opA | opB;
			mipsPkg::aluXor: result = opA ^ opB;
			mipsPkg::aluSlt: result = {31'b0, signedLess};
			mipsPkg::aluSltu: result = {31'b0, unsignedLess};
			mipsPkg::aluSll: result = opB << shiftAmount;
			mipsPkg::aluSrl: result = opB >> shiftAmount;
			mipsPkg::aluSra: result = $signed(opB) >>> shiftAmount; // Sign fill
			mipsPkg::aluLui: result = opB;
			mipsPkg::aluMfhi: result = hi;
			mipsPkg::aluMflo: result = lo;
			mipsPkg::memWord: begin
				result = address;
				enable = mipsPkg::beWord;
			end
			mipsPkg::memByte: begin
				result = {address[31:2], 2'b00}; // Word aligned
				enable = 4'b0001 << address[1:0]; // Lane from low bits
			end
			// Multiply, divide, moves to hi/lo and unknown ops give zero
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
			aluResult <= '0;
			byteEnable <= mipsPkg::beNone;
		end else begin
			outValid <= decValid;
			aluResult <= decValid ? result : '0;
			byteEnable <= decValid ? enable : mipsPkg::beNone;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		outValid |-> (byteEnable == mipsPkg::beNone || byteEnable == mipsPkg::beWord ||
			$onehot(byteEnable)))
		else $error("aluStage: illegal byte enable %h", byteEnable);

endmodule

`default_nettype wire

//--- logic/hiLoUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hiLoUnit (
	input  logic clk,
	input  logic rst,
	input  logic decValid,
	input  mipsPkg::aluOpT decOp,
	input  logic [31:0] opA,
	input  logic [31:0] opB,
	output logic [31:0] hi,
	output logic [31:0] lo
);

	logic [63:0] uProduct;
	logic [63:0] sProduct;
	logic [31:0] uQuot;
	logic [31:0] uRem;
	logic [31:0] sQuot;
	logic [31:0] sRem;
	logic divZero;

	assign uProduct = {32'b0, opA} * {32'b0, opB};
	assign sProduct = $signed({{32{opA[31]}}, opA}) * $signed({{32{opB[31]}}, opB});

	assign divZero = (opB == 32'b0);
	assign uQuot = opA / opB;
	assign uRem = opA % opB;
	assign sQuot = $signed(opA) / $signed(opB); // Truncates toward zero
	assign sRem = $signed(opA) % $signed(opB); // Takes dividend sign

	// Written at the end of stage 2 so the next op sees the new value
	always_ff @(posedge clk) begin
		if (rst) begin
			hi <= '0;
			lo <= '0;
		end else if (decValid) begin
			case (decOp)
				mipsPkg::aluMult: begin
					hi <= sProduct[63:32];
					lo <= sProduct[31:0];
				end
				mipsPkg::aluMultu: begin
					hi <= uProduct[63:32];
					lo <= uProduct[31:0];
				end
				mipsPkg::aluDiv: begin
					if (!divZero) begin
						lo <= sQuot;
						hi <= sRem;
					end
				end
				mipsPkg::aluDivu: begin
					if (!divZero) begin
						lo <= uQuot;
						hi <= uRem;
					end
				end
				mipsPkg::aluMthi: hi <= opA;
				mipsPkg::aluMtlo: lo <= opA;
				default: ;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst) !$isunknown({hi, lo}))
		else $error("hiLoUnit: hi or lo holds unknown bits");

endmodule

`default_nettype wire

//--- logic/mipsExecute.sv
`timescale 1ns/1ps
`default_nettype none

module mipsExecute (
	input  logic clk,
	input  logic rst,
	input  logic inValid,
	input  logic [31:0] instruction,
	input  logic [31:0] readData1,
	input  logic [31:0] readData2,
	output logic outValid,
	output logic [31:0] aluResult,
	output logic [3:0] byteEnable
);

	logic decValid;
	mipsPkg::aluOpT decOp;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [4:0] shiftAmount;
	logic [31:0] hi;
	logic [31:0] lo;

	decodeStage decoder (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.instruction(instruction),
		.readData1(readData1),
		.readData2(readData2),
		.decValid(decValid),
		.decOp(decOp),
		.opA(opA),
		.opB(opB),
		.shiftAmount(shiftAmount)
	);

	aluStage alu (
		.clk(clk),
		.rst(rst),
		.decValid(decValid),
		.decOp(decOp),
		.opA(opA),
		.opB(opB),
		.shiftAmount(shiftAmount),
		.hi(hi),
		.lo(lo),
		.outValid(outValid),
		.aluResult(aluResult),
		.byteEnable(byteEnable)
	);

	// Runs beside the ALU stage on the same decoded ops
	hiLoUnit hiLo (
		.clk(clk),
		.rst(rst),
		.decValid(decValid),
		.decOp(decOp),
		.opA(opA),
		.opB(opB),
		.hi(hi),
		.lo(lo)
	);

endmodule

`default_nettype wire

//--- test/executeModel.svh
`ifndef EXECUTE_MODEL_SVH
`define EXECUTE_MODEL_SVH

// Expected result of one instruction, from the opcode and function tables
function automatic logic [31:0] modelResult(input logic [31:0] instr, input logic [31:0] r1,
		input logic [31:0] r2, input logic [31:0] hiNow, input logic [31:0] loNow);
	logic [5:0] op;
	logic [5:0] fn;
	logic [4:0] sh;
	logic [31:0] se;
	logic [31:0] ze;
	logic [31:0] ea;
	op = instr[31:26];
	fn = instr[5:0];
	sh = instr[10:6];
	se = {{16{instr[15]}}, instr[15:0]};
	ze = {16'h0000, instr[15:0]};
	ea = r1 + se;
	if (op == mipsPkg::opSpecial) begin
		case (fn)
			mipsPkg::fnAddu: return r1 + r2;
			mipsPkg::fnSubu: return r1 - r2;
			mipsPkg::fnAnd: return r1 & r2;
			mipsPkg::fnOr: return r1 | r2;
			mipsPkg::fnXor: return r1 ^ r2;
			mipsPkg::fnSlt: return ($signed(r1) < $signed(r2)) ? 32'd1 : 32'd0;
			mipsPkg::fnSltu: return (r1 < r2) ? 32'd1 : 32'd0;
			mipsPkg::fnSll: return r2 << sh;
			mipsPkg::fnSrl: return r2 >> sh;
			mipsPkg::fnSra: return $signed(r2) >>> sh;
			mipsPkg::fnSllv: return r2 << r1[4:0];
			mipsPkg::fnSrlv: return r2 >> r1[4:0];
			mipsPkg::fnSrav: return $signed(r2) >>> r1[4:0];
			mipsPkg::fnMfhi: return hiNow;
			mipsPkg::fnMflo: return loNow;
			default: return 32'h0;
		endcase
	end
	case (op)
		mipsPkg::opAddiu: return ea;
		mipsPkg::opSlti: return ($signed(r1) < $signed(se)) ? 32'd1 : 32'd0;
		mipsPkg::opSltiu: return (r1 < ze) ? 32'd1 : 32'd0;
		mipsPkg::opAndi: return r1 & ze;
		mipsPkg::opOri: return r1 | ze;
		mipsPkg::opXori: return r1 ^ ze;
		mipsPkg::opLui: return {instr[15:0], 16'h0000};
		mipsPkg::opLw, mipsPkg::opSw: return ea;
		mipsPkg::opLb, mipsPkg::opLbu, mipsPkg::opSb: return {ea[31:2], 2'b00};
		default: return 32'h0;
	endcase
endfunction

function automatic logic [3:0] modelEnable(input logic [31:0] instr, input logic [31:0] r1);
	logic [31:0] ea;
	ea = r1 + {{16{instr[15]}}, instr[15:0]};
	case (instr[31:26])
		mipsPkg::opLw, mipsPkg::opSw: return mipsPkg::beWord;
		mipsPkg::opLb, mipsPkg::opLbu, mipsPkg::opSb: return 4'b0001 << ea[1:0];
		default: return mipsPkg::beNone;
	endcase
endfunction

// Hi and lo after the instruction, in program order
task automatic updateHiLo(input logic [31:0] instr, input logic [31:0] r1, input logic [31:0] r2,
		inout logic [31:0] hiReg, inout logic [31:0] loReg);
	logic [63:0] prod;
	if (instr[31:26] == mipsPkg::opSpecial) begin
		case (instr[5:0])
			mipsPkg::fnMult: begin
				prod = $signed({{32{r1[31]}}, r1}) * $signed({{32{r2[31]}}, r2});
				hiReg = prod[63:32];
				loReg = prod[31:0];
			end
			mipsPkg::fnMultu: begin
				prod = {32'h0, r1} * {32'h0, r2};
				hiReg = prod[63:32];
				loReg = prod[31:0];
			end
			mipsPkg::fnDiv: if (r2 != 32'h0) begin
				loReg = $signed(r1) / $signed(r2);
				hiReg = $signed(r1) % $signed(r2);
			end
			mipsPkg::fnDivu: if (r2 != 32'h0) begin
				loReg = r1 / r2;
				hiReg = r1 % r2;
			end
			mipsPkg::fnMthi: hiReg = r1;
			mipsPkg::fnMtlo: loReg = r1;
			default: ;
		endcase
	end
endtask

`endif

//--- test/mipsExecuteTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsExecuteTb;

	localparam int randomCount = 400;
	localparam int directedBudget = 64; // Directed ops and gap cycles
	localparam time clockPeriod = 100ns;

	logic clk;
	logic rst;
	logic inValid;
	logic [31:0] instruction;
	logic [31:0] readData1;
	logic [31:0] readData2;
	logic outValid;
	logic [31:0] aluResult;
	logic [3:0] byteEnable;

	logic [31:0] resQ[$];
	logic [3:0] beQ[$];
	int dueQ[$];
	logic headValid;
	logic [31:0] headResult;
	logic [3:0] headBe;
	int headDue;
	int cycleCount;
	logic [31:0] modelHi;
	logic [31:0] modelLo;
	logic [5:0] specialFns[18];
	logic [5:0] immOps[12];

	`include "executeModel.svh"

	mipsExecute dut (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.instruction(instruction),
		.readData1(readData1),
		.readData2(readData2),
		.outValid(outValid),
		.aluResult(aluResult),
		.byteEnable(byteEnable)
	);

	always #(clockPeriod / 2) clk = ~clk;

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic refreshHead();
		headValid = resQ.size() > 0;
		headResult = headValid ? resQ[0] : 32'h0;
		headBe = headValid ? beQ[0] : 4'h0;
		headDue = headValid ? dueQ[0] : 0;
	endtask

	always @(posedge clk) begin
		if (outValid && resQ.size() > 0) begin
			void'(resQ.pop_front());
			void'(beQ.pop_front());
			void'(dueQ.pop_front());
		end
		cycleCount++;
		refreshHead();
	end

	// Output expected two edges after the instruction is sampled
	task automatic issue(input logic [31:0] instr, input logic [31:0] r1, input logic [31:0] r2);
		@(posedge clk);
		#5;
		inValid = 1'b1;
		instruction = instr;
		readData1 = r1;
		readData2 = r2;
		resQ.push_back(modelResult(instr, r1, r2, modelHi, modelLo));
		beQ.push_back(modelEnable(instr, r1));
		dueQ.push_back(cycleCount + 2);
		updateHiLo(instr, r1, r2, modelHi, modelLo);
		refreshHead();
	endtask

	task automatic idle();
		@(posedge clk);
		#5;
		inValid = 1'b0;
		instruction = $urandom;
	endtask

	function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] sh);
		return {mipsPkg::opSpecial, 15'($urandom), sh, fn};
	endfunction

	function automatic logic [31:0] iType(input logic [5:0] op, input logic [15:0] imm);
		return {op, 10'($urandom), imm};
	endfunction

	function automatic logic [31:0] pickValue();
		case ($urandom % 6)
			0: return 32'h0;
			1: return 32'hffffffff;
			2: return 32'h80000000;
			default: return $urandom;
		endcase
	endfunction

	assert property (@(posedge clk) outValid |-> headValid && headDue == cycleCount)
		else reportFailure("outValid was high with no instruction due in that cycle");
	assert property (@(posedge clk) disable iff (rst)
		(headValid && headDue <= cycleCount) |-> outValid)
		else reportFailure("outValid stayed low when an instruction was due");
	assert property (@(posedge clk) outValid |-> aluResult == headResult)
		else reportFailure($sformatf("mismatch aluResult: got %h expected %h",
			$sampled(aluResult), $sampled(headResult)));
	assert property (@(posedge clk) outValid |-> byteEnable == headBe)
		else reportFailure($sformatf("mismatch byteEnable: got %h expected %h",
			$sampled(byteEnable), $sampled(headBe)));

	initial begin
		#((randomCount + directedBudget + 10) * clockPeriod * 2);
		reportFailure("timeout: outputs did not drain in time");
	end

	initial begin
		logic [31:0] instr;
		void'($urandom(32'h3c46aa75));
		specialFns = '{mipsPkg::fnAddu, mipsPkg::fnSubu, mipsPkg::fnAnd, mipsPkg::fnOr,
			mipsPkg::fnXor, mipsPkg::fnSlt, mipsPkg::fnSltu, mipsPkg::fnSll, mipsPkg::fnSrl,
			mipsPkg::fnSra, mipsPkg::fnSllv, mipsPkg::fnSrlv, mipsPkg::fnSrav, mipsPkg::fnMult,
			mipsPkg::fnMultu, mipsPkg::fnDiv, mipsPkg::fnDivu, mipsPkg::fnMfhi};
		immOps = '{mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opSltiu, mipsPkg::opAndi,
			mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLui, mipsPkg::opLw, mipsPkg::opSw,
			mipsPkg::opLb, mipsPkg::opLbu, mipsPkg::opSb};
		clk = 1'b0;
		rst = 1'b1;
		inValid = 1'b0;
		instruction = 32'h0;
		readData1 = 32'h0;
		readData2 = 32'h0;
		modelHi = 32'h0;
		modelLo = 32'h0;
		cycleCount = 0;
		refreshHead();
		repeat (2) @(posedge clk);
		#5;
		rst = 1'b0;
		idle();
		idle();
		issue(rType(mipsPkg::fnMfhi, 5'd0), 32'h0, 32'h0); // Zero right after reset
		issue(rType(mipsPkg::fnMult, 5'd0), 32'hfffffff9, 32'h00001234);
		issue(rType(mipsPkg::fnMfhi, 5'd0), 32'h0, 32'h0);
		issue(rType(mipsPkg::fnMflo, 5'd0), 32'h0, 32'h0);
		issue(rType(mipsPkg::fnDiv, 5'd0), 32'hffffff85, 32'h00000007);
		issue(rType(mipsPkg::fnMfhi, 5'd0), 32'h0, 32'h0);
		issue(rType(mipsPkg::fnDivu, 5'd0), 32'h12345678, 32'h0); // Divide by zero
		issue(rType(mipsPkg::fnMflo, 5'd0), 32'h0, 32'h0);
		issue(rType(mipsPkg::fnMfhi, 5'd0), 32'h0, 32'h0);
		issue(rType(mipsPkg::fnMultu, 5'd0), 32'hffffffff, 32'hffffffff);
		issue(rType(mipsPkg::fnMfhi, 5'd0), 32'h0, 32'h0);
		issue(rType(mipsPkg::fnMthi, 5'd0), 32'hcafe0001, 32'h0);
		issue(rType(mipsPkg::fnMfhi, 5'd0), 32'h0, 32'h0);
		issue(rType(mipsPkg::fnMtlo, 5'd0), 32'h0badf00d, 32'h0);
		issue(rType(mipsPkg::fnMflo, 5'd0), 32'h0, 32'h0);
		issue(rType(mipsPkg::fnSra, 5'd31), 32'h0, 32'h80000000);
		issue(rType(mipsPkg::fnSrav, 5'd0), 32'hffffffe4, 32'h80000000);
		idle();
		idle();
		for (int i = 0; i < 4; i++) begin
			issue(iType(mipsPkg::opLb, 16'(i)), 32'h00001000, 32'h0);
		end
		issue(iType(mipsPkg::opSw, 16'hfffc), 32'h00002000, 32'h0);
		issue(iType(mipsPkg::opLui, 16'hbeef), 32'h0, 32'h0);
		issue({6'b111111, 26'h3ffffff}, 32'hffffffff, 32'hffffffff); // Unknown opcode
		idle();
		for (int i = 0; i < randomCount; i++) begin
			case ($urandom % 8)
				0: instr = rType(mipsPkg::fnMflo + 6'($urandom % 2) * 6'd2 - 6'd2, 5'($urandom));
				1: instr = {6'($urandom), 26'($urandom)};
				2, 3, 4: instr = iType(immOps[$urandom % 12], 16'($urandom));
				default: instr = rType(specialFns[$urandom % 18], 5'($urandom));
			endcase
			if ($urandom % 10 == 0) begin
				idle();
			end
			issue(instr, pickValue(), pickValue());
		end
		idle();
		while (resQ.size() > 0) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- mipsExecute.f
+incdir+test
logic/mipsPkg.sv
logic/decodeStage.sv
logic/aluStage.sv
logic/hiLoUnit.sv
logic/mipsExecute.sv
test/mipsExecuteTb.sv

//--- Makefile
SRCS = $(shell grep -v '^+' mipsExecute.f) test/executeModel.svh

.PHONY: all run clean

all: obj_dir/VmipsExecuteTb

obj_dir/VmipsExecuteTb: $(SRCS) mipsExecute.f
	verilator --binary --timing --assert -f mipsExecute.f --top-module mipsExecuteTb -o VmipsExecuteTb

run: obj_dir/VmipsExecuteTb
	./obj_dir/VmipsExecuteTb | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
